/* Makefile */
# Verilator lint and simulation of the AXI bridge testbench

TOP := axiBridgeTb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f sources.f --top-module $(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

/* source/axiBridge.sv */
`timescale 1ns/1ps

module axiBridge import axiBridgePkg::*; #(
    parameter int lineWords = LINE_WORDS
) (
    input  logic                        clk,
    input  logic                        rst,

    // AXI read address and data
    output logic                        arValid,
    input  logic                        arReady,
    output axiAddr_t                    arPayload,
    input  logic                        rValid,
    output logic                        rReady,
    input  axiRData_t                   rPayload,

    // AXI write address, data and response
    output logic                        awValid,
    input  logic                        awReady,
    output axiAddr_t                    awPayload,
    output logic                        wValid,
    input  logic                        wReady,
    output axiWData_t                   wPayload,
    input  logic                        bValid,
    output logic                        bReady,
    input  axiWResp_t                   bPayload,   // Response code not checked

    // CPU instruction port
    input  logic                        instReqValid,
    output logic                        instReqReady,
    input  instReq_t                    instReq,
    output logic                        instRespValid,
    input  logic                        instRespReady,
    output logic [lineWords*WORD_W-1:0] instLine,

    // CPU data port
    input  logic                        dataReqValid,
    output logic                        dataReqReady,
    input  dataReq_t                    dataReq,
    output logic                        dataRespValid,
    input  logic                        dataRespReady,
    output logic [WORD_W-1:0]           dataWord
);

    logic     instBusy, dataBusy;
    instReq_t instHeld;
    dataReq_t dataHeld;
    logic     instRelease, dataRelease;
    logic     startLine, beatValid;

    requestSlot #(.payload_t(instReq_t)) instSlot (
        .clk         (clk),
        .rst         (rst),
        .reqValid    (instReqValid),
        .reqPayload  (instReq),
        .reqReady    (instReqReady),
        .slotRelease (instRelease),
        .busy        (instBusy),
        .held        (instHeld)
    );

    requestSlot #(.payload_t(dataReq_t)) dataSlot (
        .clk         (clk),
        .rst         (rst),
        .reqValid    (dataReqValid),
        .reqPayload  (dataReq),
        .reqReady    (dataReqReady),
        .slotRelease (dataRelease),
        .busy        (dataBusy),
        .held        (dataHeld)
    );

    lineAssembler #(.lineWords(lineWords)) i_lineAssembler (
        .clk       (clk),
        .rst       (rst),
        .startLine (startLine),
        .beatValid (beatValid),
        .beat      (rPayload),
        .line      (instLine),
        .firstWord (dataWord)
    );

    bridgeControl #(.lineWords(lineWords)) i_bridgeControl (
        .clk           (clk),
        .rst           (rst),
        .instBusy      (instBusy),
        .instHeld      (instHeld),
        .dataBusy      (dataBusy),
        .dataHeld      (dataHeld),
        .arValid       (arValid),
        .arReady       (arReady),
        .arPayload     (arPayload),
        .rValid        (rValid),
        .rReady        (rReady),
        .rPayload      (rPayload),
        .awValid       (awValid),
        .awReady       (awReady),
        .awPayload     (awPayload),
        .wValid        (wValid),
        .wReady        (wReady),
        .wPayload      (wPayload),
        .bValid        (bValid),
        .bReady        (bReady),
        .startLine     (startLine),
        .beatValid     (beatValid),
        .instRelease   (instRelease),
        .dataRelease   (dataRelease),
        .instRespValid (instRespValid),
        .instRespReady (instRespReady),
        .dataRespValid (dataRespValid),
        .dataRespReady (dataRespReady)
    );

endmodule

/* source/axiBridgePkg.sv */
package axiBridgePkg;

    // ************************************************************************
    // Bus constants
    // ************************************************************************

    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;               // Beats per instruction line
    localparam int STRB_W     = WORD_W / 8;

    localparam int ID_W    = 4;
    localparam int LEN_W   = 4;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;

    localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;
    localparam logic [BURST_W-1:0] BURST_WRAP = 2'b10;
    localparam logic [SIZE_W-1:0]  SIZE_WORD  = 3'b010; // 4 bytes per beat

    localparam logic [ID_W-1:0] INST_ID = 4'd0;
    localparam logic [ID_W-1:0] DATA_ID = 4'd1;

    // ************************************************************************
    // AXI channel payloads
    // ************************************************************************

    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [WORD_W-1:0]  addr;
        logic [LEN_W-1:0]   len;                 // Beats minus one
        logic [SIZE_W-1:0]  size;
        logic [BURST_W-1:0] burst;
    } axiAddr_t;                                 // Shared by AR and AW

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [WORD_W-1:0] data;
        logic              last;
    } axiRData_t;

    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axiWData_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
    } axiWResp_t;

    // ************************************************************************
    // CPU requests
    // ************************************************************************

    typedef struct packed {
        logic [WORD_W-1:0] pc;
    } instReq_t;

    typedef struct packed {
        logic [WORD_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
        logic              writeEn;
    } dataReq_t;

endpackage

/* source/bridgeControl.sv */
`timescale 1ns/1ps

module bridgeControl import axiBridgePkg::*; #(
    parameter int lineWords = LINE_WORDS
) (
    input  logic      clk,
    input  logic      rst,

    input  logic      instBusy,
    input  instReq_t  instHeld,
    input  logic      dataBusy,
    input  dataReq_t  dataHeld,

    output logic      arValid,
    input  logic      arReady,
    output axiAddr_t  arPayload,

    input  logic      rValid,
    output logic      rReady,
    input  axiRData_t rPayload,

    output logic      awValid,
    input  logic      awReady,
    output axiAddr_t  awPayload,

    output logic      wValid,
    input  logic      wReady,
    output axiWData_t wPayload,

    input  logic      bValid,
    output logic      bReady,

    output logic      startLine,
    output logic      beatValid,
    output logic      instRelease,
    output logic      dataRelease,

    output logic      instRespValid,
    input  logic      instRespReady,
    output logic      dataRespValid,
    input  logic      dataRespReady
);

    localparam int OFFSET_W = $clog2(lineWords * STRB_W);
    localparam logic [WORD_W-1:0] LINE_MASK = {WORD_W{1'b1}} << OFFSET_W;

    typedef enum logic [2:0] {
        rdIdle,
        rdCollectInst,
        rdCollectData,
        rdRespondInst,
        rdRespondData
    } rdState_t;

    typedef enum logic [1:0] {
        wrIdle,
        wrSendWord,
        wrWaitResp
    } wrState_t;

    rdState_t rdState, rdNext;
    wrState_t wrState, wrNext;

    logic dataRdPending;
    logic dataWrPending;
    logic arHold;                                // AR offered but not yet taken
    logic arHoldData;
    logic arSelData;
    logic arFire, rFire, awFire, wFire, bFire;

    assign dataRdPending = dataBusy && !dataHeld.writeEn;
    assign dataWrPending = dataBusy && dataHeld.writeEn;

    assign arFire = arValid && arReady;
    assign rFire  = rValid && rReady;
    assign awFire = awValid && awReady;
    assign wFire  = wValid && wReady;
    assign bFire  = bValid && bReady;

    // ************************************************************************
    // Read channel
    // ************************************************************************

    // Choice is frozen once AR is offered so the payload stays stable
    assign arSelData = arHold ? arHoldData : dataRdPending;
    assign arValid   = (rdState == rdIdle) && (dataRdPending || instBusy);

    always_ff @(posedge clk) begin
        if (rst) begin
            arHold <= 1'b0;
        end else begin
            arHold <= arValid && !arReady;
        end
    end

    always_ff @(posedge clk) begin
        arHoldData <= arSelData;
    end

    always_comb begin
        arPayload.size  = SIZE_WORD;
        arPayload.burst = BURST_WRAP;
        if (arSelData) begin
            arPayload.id   = DATA_ID;
            arPayload.addr = dataHeld.addr;
            arPayload.len  = '0;
        end else begin
            arPayload.id   = INST_ID;
            arPayload.addr = instHeld.pc & LINE_MASK;   // Line aligned
            arPayload.len  = LEN_W'(lineWords - 1);
        end
    end

    always_comb begin
        rdNext = rdState;
        case (rdState)
            rdIdle: begin
                if (arFire) begin
                    rdNext = arSelData ? rdCollectData : rdCollectInst;
                end
            end
            rdCollectInst: begin
                if (rFire && rPayload.last) begin
                    rdNext = rdRespondInst;
                end
            end
            rdCollectData: begin
                if (rFire && rPayload.last) begin
                    rdNext = rdRespondData;
                end
            end
            rdRespondInst: begin
                if (instRespReady) begin
                    rdNext = rdIdle;
                end
            end
            rdRespondData: begin
                if (dataRespReady) begin
                    rdNext = rdIdle;
                end
            end
            default: rdNext = rdIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdState <= rdIdle;
        end else begin
            rdState <= rdNext;
        end
    end

    assign rReady        = (rdState == rdCollectInst) || (rdState == rdCollectData);
    assign startLine     = arFire;               // Resets the beat counter
    assign beatValid     = rFire;
    assign instRespValid = (rdState == rdRespondInst);
    assign dataRespValid = (rdState == rdRespondData);
    assign instRelease   = instRespValid && instRespReady;

    // ************************************************************************
    // Write channel
    // ************************************************************************

    assign awValid = (wrState == wrIdle) && dataWrPending;
    assign wValid  = (wrState == wrSendWord);
    assign bReady  = (wrState == wrWaitResp);

    always_comb begin
        awPayload.id    = DATA_ID;
        awPayload.addr  = dataHeld.addr;
        awPayload.len   = '0;                    // Single beat
        awPayload.size  = SIZE_WORD;
        awPayload.burst = BURST_INCR;
    end

    always_comb begin
        wPayload.data = dataHeld.wdata;
        wPayload.strb = dataHeld.strb;
        wPayload.last = 1'b1;
    end

    always_comb begin
        wrNext = wrState;
        case (wrState)
            wrIdle:     if (awFire) wrNext = wrSendWord;
            wrSendWord: if (wFire)  wrNext = wrWaitResp;
            wrWaitResp: if (bFire)  wrNext = wrIdle;
            default:    wrNext = wrIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrState <= wrIdle;
        end else begin
            wrState <= wrNext;
        end
    end

    // Data slot is freed by a read response or a write response
    assign dataRelease = (dataRespValid && dataRespReady) || bFire;

endmodule

/* source/lineAssembler.sv */
`timescale 1ns/1ps

// Collects the beats of a read burst into one line register.
// Beat k of a burst is written into word k.
module lineAssembler import axiBridgePkg::*; #(
    parameter int lineWords = LINE_WORDS
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        startLine,  // AR accepted
    input  logic                        beatValid,  // R beat accepted
    input  axiRData_t                   beat,

    output logic [lineWords*WORD_W-1:0] line,
    output logic [WORD_W-1:0]           firstWord
);

    localparam int CNT_W = (lineWords > 1) ? $clog2(lineWords) : 1;

    logic [CNT_W-1:0]            beatIdx;
    logic [lineWords*WORD_W-1:0] lineReg;

    // ************************************************************************
    // Beat counter
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            beatIdx <= '0;
        end else if (startLine) begin
            beatIdx <= '0;
        end else if (beatValid) begin
            beatIdx <= beatIdx + 1'b1;
        end
    end

    // ************************************************************************
    // Line storage
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (beatValid) begin
            lineReg[beatIdx*WORD_W +: WORD_W] <= beat.data;
        end
    end

    assign line      = lineReg;
    assign firstWord = lineReg[WORD_W-1:0];     // Single-beat data reads

endmodule

/* source/requestSlot.sv */
`timescale 1ns/1ps

// One-entry holding register between a CPU port and the bridge control.
// The entry is free again one cycle after the control logic releases it.
module requestSlot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     reqValid,
    input  payload_t reqPayload,
    output logic     reqReady,

    input  logic     slotRelease,              // Pulse from bridgeControl

    output logic     busy,
    output payload_t held
);

    logic accept;

    assign accept   = reqValid && reqReady;
    assign reqReady = ~busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (slotRelease) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held <= reqPayload;                  // Stable while busy
        end
    end

endmodule

/* sources.f */
source/axiBridgePkg.sv
source/requestSlot.sv
source/lineAssembler.sv
source/bridgeControl.sv
source/axiBridge.sv
verification/axiBridge_assertions.sv
verification/axiBridgeTb.sv

/* verification/axiBridgeTb.sv */
`timescale 1ns/1ps

module axiBridgeTb import axiBridgePkg::*; ();

    localparam int lineWords = LINE_WORDS;
    localparam int TIMEOUT   = 2000;             // Cycles per wait

    typedef logic [lineWords*WORD_W-1:0] line_t;

    logic              clk = 1'b0;
    logic              rst;
    logic              arValid, arReady, rValid, rReady;
    axiAddr_t          arPayload, awPayload;
    axiRData_t         rPayload;
    logic              awValid, awReady, wValid, wReady, bValid, bReady;
    axiWData_t         wPayload;
    axiWResp_t         bPayload;
    logic              instReqValid, instReqReady, instRespValid, instRespReady;
    instReq_t          instReq;
    line_t             instLine;
    logic              dataReqValid, dataReqReady, dataRespValid, dataRespReady;
    dataReq_t          dataReq;
    logic [WORD_W-1:0] dataWord;

    logic [WORD_W-1:0] memData [logic [WORD_W-1:0]];    // Words written over AXI
    logic [WORD_W-1:0] modelData [logic [WORD_W-1:0]];  // Model of the same memory
    axiAddr_t          expInstAr[$], expDataAr[$], expAw[$];
    axiWData_t         expW[$];

    always #4 clk = ~clk;

    axiBridge #(.lineWords(lineWords)) i_dut (.*);

    bind bridgeControl axiBridge_assertions i_assertions (.*);

    // ************************************************************************
    // Helpers and compare tasks
    // ************************************************************************

    task automatic nextCycle();
        @(posedge clk);
        #1;                                      // Inputs change just after the edge
    endtask

    task automatic abortRun(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic failValue(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped after a mismatch");
    endtask

    task automatic checkFlag(input string what, input logic got, input logic expected);
        if (got !== expected)
            failValue($sformatf("%s is %b, expected %b", what, got, expected));
    endtask

    task automatic checkWord(input string what, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] expected);
        if (got !== expected)
            failValue($sformatf("%s is %h, expected %h", what, got, expected));
    endtask

    task automatic checkLine(input line_t got, input line_t expected);
        if (got !== expected)
            failValue($sformatf("instruction line is %h, expected %h", got, expected));
    endtask

    task automatic checkAddr(input string what, input axiAddr_t got, input axiAddr_t expected);
        if (got !== expected)
            failValue($sformatf("%s id %0d addr %h len %0d size %0d burst %0d, expected %h",
                                what, got.id, got.addr, got.len, got.size, got.burst,
                                expected));
    endtask

    task automatic checkWData(input axiWData_t got, input axiWData_t expected);
        if (got !== expected)
            failValue($sformatf("W data %h strb %b last %b, expected %h %b %b", got.data,
                                got.strb, got.last, expected.data, expected.strb, expected.last));
    endtask

    function automatic logic [WORD_W-1:0] memWord(input logic [WORD_W-1:0] addr);
        logic [WORD_W-1:0] wordAddr;
        wordAddr = {addr[WORD_W-1:2], 2'b00};
        return memData.exists(wordAddr) ? memData[wordAddr] : ~wordAddr;
    endfunction

    function automatic logic [WORD_W-1:0] modelWord(input logic [WORD_W-1:0] addr);
        logic [WORD_W-1:0] wordAddr;
        wordAddr = {addr[WORD_W-1:2], 2'b00};
        return modelData.exists(wordAddr) ? modelData[wordAddr] : ~wordAddr;
    endfunction

    function automatic axiAddr_t makeAddr(input logic [ID_W-1:0] id,
                                          input logic [WORD_W-1:0] addr,
                                          input logic [LEN_W-1:0] len,
                                          input logic [BURST_W-1:0] burst);
        axiAddr_t a;
        a.id    = id;
        a.addr  = addr;
        a.len   = len;
        a.size  = SIZE_WORD;
        a.burst = burst;
        return a;
    endfunction

    function automatic logic [WORD_W-1:0] randomDataAddr();
        return 32'h8000_0000 | ($urandom() & 32'h0000_00FC);   // Apart from fetch region
    endfunction

    // Handshake checker bound into bridgeControl
    always @(negedge clk) begin
        if (i_dut.i_bridgeControl.i_assertions.failCount != 0)
            abortRun("a handshake assertion failed in bridgeControl");
    end

    // ************************************************************************
    // AXI memory with random delays
    // ************************************************************************

    task automatic matchAr(input axiAddr_t got);
        if (got.id == INST_ID && expInstAr.size() > 0)
            checkAddr("AR", got, expInstAr.pop_front());
        else if (got.id == DATA_ID && expDataAr.size() > 0)
            checkAddr("AR", got, expDataAr.pop_front());
        else
            abortRun("read address arrived with no matching request outstanding");
    endtask

    initial begin : readMemory
        axiAddr_t ar;
        int       cycles;
        arReady  = 1'b0;
        rValid   = 1'b0;
        rPayload = '0;
        forever begin
            nextCycle();
            arReady = ($urandom() % 2 == 0);
            @(negedge clk);
            if (arValid && arReady) begin
                ar = arPayload;
                nextCycle();
                arReady = 1'b0;
                matchAr(ar);
                for (int beatNo = 0; beatNo <= int'(ar.len); beatNo++) begin
                    repeat ($urandom() % 3) nextCycle();
                    rValid        = 1'b1;
                    rPayload.id   = ar.id;
                    rPayload.data = memWord(ar.addr + 4 * beatNo);
                    rPayload.last = (beatNo == int'(ar.len));
                    cycles        = 0;
                    @(negedge clk);
                    while (!rReady) begin
                        cycles++;
                        if (cycles > TIMEOUT)
                            abortRun("read beat was never accepted by the bridge");
                        @(negedge clk);
                    end
                    nextCycle();
                    rValid = 1'b0;
                end
            end
        end
    end

    initial begin : writeMemory
        axiAddr_t          aw;
        axiWData_t         w, wExpected;
        logic [WORD_W-1:0] word;
        int                cycles;
        awReady  = 1'b0;
        wReady   = 1'b0;
        bValid   = 1'b0;
        bPayload = '0;
        forever begin
            nextCycle();
            awReady = ($urandom() % 2 == 0);
            @(negedge clk);
            if (awValid && awReady) begin
                aw = awPayload;
                nextCycle();
                awReady = 1'b0;
                if (expAw.size() == 0 || expW.size() == 0) begin
                    abortRun("write address arrived with no write outstanding");
                end else begin
                    checkAddr("AW", aw, expAw.pop_front());
                    wExpected = expW.pop_front();
                end
                repeat ($urandom() % 3) nextCycle();
                wReady = 1'b1;
                cycles = 0;
                @(negedge clk);
                while (!wValid) begin
                    cycles++;
                    if (cycles > TIMEOUT)
                        abortRun("write data was never offered by the bridge");
                    @(negedge clk);
                end
                w = wPayload;
                nextCycle();
                wReady = 1'b0;
                checkWData(w, wExpected);
                word = memWord(aw.addr);
                for (int b = 0; b < STRB_W; b++) begin
                    if (w.strb[b])
                        word[b*8 +: 8] = w.data[b*8 +: 8];
                end
                memData[{aw.addr[WORD_W-1:2], 2'b00}] = word;
                repeat ($urandom() % 3) nextCycle();
                bValid        = 1'b1;
                bPayload.id   = aw.id;
                bPayload.resp = 2'b00;           // OKAY
                cycles        = 0;
                @(negedge clk);
                while (!bReady) begin
                    cycles++;
                    if (cycles > TIMEOUT)
                        abortRun("write response was never accepted by the bridge");
                    @(negedge clk);
                end
                nextCycle();
                bValid = 1'b0;
            end
        end
    end

    // ************************************************************************
    // CPU side
    // ************************************************************************

    task automatic sendData(input dataReq_t req);
        int cycles;
        cycles       = 0;
        dataReq      = req;
        dataReqValid = 1'b1;
        @(negedge clk);
        while (!dataReqReady) begin
            cycles++;
            if (cycles > TIMEOUT)
                abortRun("data request was never accepted");
            @(negedge clk);
        end
        nextCycle();
        dataReqValid = 1'b0;
    endtask

    task automatic readWord(input logic [WORD_W-1:0] addr);
        dataReq_t          req;
        logic [WORD_W-1:0] got;
        logic              done;
        int                cycles;
        req       = '0;
        req.addr  = addr;
        req.wdata = $urandom();                  // Ignored on reads
        expDataAr.push_back(makeAddr(DATA_ID, addr, '0, BURST_WRAP));
        sendData(req);
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            dataRespReady = ($urandom() % 4 != 0);   // Random back-pressure
            @(negedge clk);
            done = dataRespValid && dataRespReady;
            got  = dataWord;
            cycles++;
            if (!done && cycles > TIMEOUT)
                abortRun("data read response never arrived");
            nextCycle();
        end
        dataRespReady = 1'b0;
        checkWord("data read word", got, modelWord(addr));
    endtask

    task automatic writeWord(input logic [WORD_W-1:0] addr, input logic [WORD_W-1:0] data,
                             input logic [STRB_W-1:0] strb);
        dataReq_t          req;
        axiWData_t         w;
        logic [WORD_W-1:0] mask;
        int                cycles;
        req.addr    = addr;
        req.wdata   = data;
        req.strb    = strb;
        req.writeEn = 1'b1;
        w.data      = data;
        w.strb      = strb;
        w.last      = 1'b1;
        expAw.push_back(makeAddr(DATA_ID, addr, '0, BURST_INCR));
        expW.push_back(w);
        for (int b = 0; b < STRB_W; b++)
            mask[b*8 +: 8] = {8{strb[b]}};
        modelData[{addr[WORD_W-1:2], 2'b00}] = (modelWord(addr) & ~mask) | (data & mask);
        sendData(req);
        cycles = 0;
        @(negedge clk);
        while (!dataReqReady) begin              // Slot frees after B
            cycles++;
            if (cycles > TIMEOUT)
                abortRun("data write never completed");
            @(negedge clk);
        end
        nextCycle();
    endtask

    task automatic fetchLine(input logic [WORD_W-1:0] pc);
        logic [WORD_W-1:0] base;
        line_t             expected, got;
        logic              done;
        int                cycles;
        base = pc & ~WORD_W'(lineWords * STRB_W - 1);
        for (int k = 0; k < lineWords; k++)
            expected[k*WORD_W +: WORD_W] = modelWord(base + 4 * k);
        expInstAr.push_back(makeAddr(INST_ID, base, LEN_W'(lineWords - 1), BURST_WRAP));
        instReq.pc   = pc;
        instReqValid = 1'b1;
        cycles       = 0;
        @(negedge clk);
        while (!instReqReady) begin
            cycles++;
            if (cycles > TIMEOUT)
                abortRun("instruction request was never accepted");
            @(negedge clk);
        end
        nextCycle();
        instReqValid = 1'b0;
        cycles       = 0;
        done         = 1'b0;
        while (!done) begin
            instRespReady = ($urandom() % 4 != 0);
            @(negedge clk);
            done = instRespValid && instRespReady;
            got  = instLine;
            cycles++;
            if (!done && cycles > TIMEOUT)
                abortRun("instruction line never arrived");
            nextCycle();
        end
        instRespReady = 1'b0;
        checkLine(got, expected);
    endtask

    task automatic runInstTraffic(input int count);
        repeat (count) fetchLine($urandom() & 32'h000F_FFFF);
    endtask

    task automatic runDataTraffic(input int count);
        logic [WORD_W-1:0] addr;
        repeat (count) begin
            addr = randomDataAddr();
            if ($urandom() % 2 == 0)
                readWord(addr);
            else
                writeWord(addr, $urandom(), STRB_W'($urandom()));
        end
    endtask

    // ************************************************************************
    // Test sequence
    // ************************************************************************

    initial begin : mainSequence
        logic [WORD_W-1:0] addr;
        void'($urandom(32'h994f60fa));
        rst           = 1'b1;
        instReqValid  = 1'b0;
        instReq       = '0;
        instRespReady = 1'b0;
        dataReqValid  = 1'b0;
        dataReq       = '0;
        dataRespReady = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);                          // Idle outputs after reset
        checkFlag("arValid", arValid, 1'b0);
        checkFlag("awValid", awValid, 1'b0);
        checkFlag("wValid", wValid, 1'b0);
        checkFlag("rReady", rReady, 1'b0);
        checkFlag("bReady", bReady, 1'b0);
        checkFlag("instRespValid", instRespValid, 1'b0);
        checkFlag("dataRespValid", dataRespValid, 1'b0);
        checkFlag("instReqReady", instReqReady, 1'b1);
        checkFlag("dataReqReady", dataReqReady, 1'b1);
        nextCycle();

        runInstTraffic(8);
        repeat (8) readWord(randomDataAddr());
        repeat (8) begin
            addr = randomDataAddr();
            writeWord(addr, $urandom(), STRB_W'($urandom()));
            readWord(addr);                      // Merged value comes back
        end
        fork
            runInstTraffic(30);
            runDataTraffic(60);
        join

        if (i_dut.i_bridgeControl.i_assertions.failCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verification/axiBridge_assertions.sv */
`timescale 1ns/1ps

module axiBridge_assertions import axiBridgePkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      arValid,
    input logic      arReady,
    input axiAddr_t  arPayload,
    input logic      awValid,
    input logic      awReady,
    input axiAddr_t  awPayload,
    input logic      wValid,
    input logic      wReady,
    input axiWData_t wPayload,
    input logic      instRespValid,
    input logic      instRespReady,
    input logic      dataRespValid,
    input logic      dataRespReady
);

    int failCount = 0;                           // Failed assertions so far

    // Each valid holds with its payload until the other side is ready

    arHeld: assert property (@(posedge clk) disable iff (rst)
        arValid && !arReady |=> arValid && $stable(arPayload))
        else begin
            failCount++;
            $error("AR valid or payload changed before arReady");
        end

    awHeld: assert property (@(posedge clk) disable iff (rst)
        awValid && !awReady |=> awValid && $stable(awPayload))
        else begin
            failCount++;
            $error("AW valid or payload changed before awReady");
        end

    wHeld: assert property (@(posedge clk) disable iff (rst)
        wValid && !wReady |=> wValid && $stable(wPayload))
        else begin
            failCount++;
            $error("W valid or payload changed before wReady");
        end

    instRespHeld: assert property (@(posedge clk) disable iff (rst)
        instRespValid && !instRespReady |=> instRespValid)
        else begin
            failCount++;
            $error("Instruction response dropped before instRespReady");
        end

    dataRespHeld: assert property (@(posedge clk) disable iff (rst)
        dataRespValid && !dataRespReady |=> dataRespValid)
        else begin
            failCount++;
            $error("Data response dropped before dataRespReady");
        end

endmodule
